//--- lc4_alu.sv
// LC4 execute-stage ALU
// arithmetic, logic, CONST, load/store address and branch target
`include "lc4_settings.svh"

module lc4_alu import lc4_pkg::*; (
    input  lc4_insn_u i_insn,
    input  lc4_word_t i_pc,
    input  lc4_word_t i_rs,
    input  lc4_word_t i_rt,
    output lc4_word_t o_result
);

    lc4_word_t imm5_sx, imm6_sx, imm9_sx;

    assign imm5_sx = {{(`LC4_XLEN-5){i_insn.i.imm5[4]}}, i_insn.i.imm5};
    assign imm6_sx = {{(`LC4_XLEN-6){i_insn.m.imm6[5]}}, i_insn.m.imm6};
    assign imm9_sx = {{(`LC4_XLEN-9){i_insn.b.imm9[8]}}, i_insn.b.imm9};

    always_comb begin
        o_result = '0;
        case (i_insn.r.opcode)
            OP_BR:    o_result = i_pc + 1'b1 + imm9_sx;   // target, used only when taken
            OP_ARITH: begin
                if (i_insn.i.imm_flag) begin
                    o_result = i_rs + imm5_sx;
                end else if (i_insn.r.subop == SUB_SUB) begin
                    o_result = i_rs - i_rt;
                end else begin
                    o_result = i_rs + i_rt;
                end
            end
            OP_LOGIC: begin
                if (i_insn.i.imm_flag) begin
                    o_result = i_rs & imm5_sx;
                end else begin
                    case (i_insn.r.subop)
                        SUB_OR:  o_result = i_rs | i_rt;
                        SUB_XOR: o_result = i_rs ^ i_rt;
                        default: o_result = i_rs & i_rt;
                    endcase
                end
            end
            OP_LDR, OP_STR: o_result = i_rs + imm6_sx;    // effective address
            OP_CONST:       o_result = imm9_sx;
            default: ;
        endcase
    end

endmodule

//--- lc4_chk.sv
// LC4 pipeline assertions
// reset values of the trace and store strobe, trace enable consistency
module lc4_chk import lc4_pkg::*; (
    input logic          gwe,
    input logic          i_rst_n,
    input lc4_wb_t       i_wb,
    input lc4_dmem_req_t i_dmem
);
    timeunit 1ns;
    timeprecision 100ps;

    a_reset_quiet: assert property (@(posedge gwe)
        !i_rst_n |-> (!i_wb.valid && !i_dmem.we))
        else $error("trace or store active during reset");

    a_we_known: assert property (@(posedge gwe) disable iff (!i_rst_n)
        !$isunknown(i_dmem.we))
        else $error("store strobe unknown");

    // enables on the trace only ever come from a real retirement
    a_wb_valid: assert property (@(posedge gwe) disable iff (!i_rst_n)
        (i_wb.rd_we || i_wb.nzp_we) |-> i_wb.valid)
        else $error("trace write enable without valid");

endmodule

bind lc4_pipeline lc4_chk u_chk (
    .gwe     (gwe),
    .i_rst_n (i_rst_n),
    .i_wb    (o_wb),
    .i_dmem  (o_dmem)
);

//--- lc4_decoder.sv
// LC4 instruction decoder
// maps the kept opcodes to register selects, read enables and write enables
module lc4_decoder import lc4_pkg::*; (
    input  lc4_insn_u i_insn,
    output lc4_ctrl_t o_ctrl
);

    logic reg_op_ok;    // register or immediate form is one we implement

    always_comb begin
        if (i_insn.i.imm_flag) begin
            reg_op_ok = 1'b1;
        end else if (i_insn.r.opcode == OP_ARITH) begin
            reg_op_ok = i_insn.r.subop inside {SUB_ADD, SUB_SUB};
        end else begin
            reg_op_ok = i_insn.r.subop inside {SUB_AND, SUB_OR, SUB_XOR};
        end
    end

    always_comb begin
        o_ctrl        = '0;
        o_ctrl.rs_sel = i_insn.r.rs;
        o_ctrl.rt_sel = i_insn.r.rt;
        o_ctrl.rd_sel = i_insn.r.rd;
        case (i_insn.r.opcode)
            OP_ARITH, OP_LOGIC: begin
                if (reg_op_ok) begin
                    o_ctrl.rs_re  = 1'b1;
                    o_ctrl.rt_re  = !i_insn.i.imm_flag;
                    o_ctrl.rd_we  = 1'b1;
                    o_ctrl.nzp_we = 1'b1;
                end
            end
            OP_LDR: begin
                o_ctrl.rs_re   = 1'b1;
                o_ctrl.rd_we   = 1'b1;
                o_ctrl.nzp_we  = 1'b1;
                o_ctrl.is_load = 1'b1;
            end
            OP_STR: begin
                o_ctrl.rt_sel   = i_insn.m.rd;  // store data sits in the rd slot
                o_ctrl.rs_re    = 1'b1;
                o_ctrl.rt_re    = 1'b1;
                o_ctrl.is_store = 1'b1;
            end
            OP_CONST: begin
                o_ctrl.rd_we  = 1'b1;
                o_ctrl.nzp_we = 1'b1;
            end
            OP_BR:   o_ctrl.is_branch = |i_insn.b.nzp;    // empty mask never branches
            default: ;
        endcase
    end

endmodule

//--- lc4_hazard_unit.sv
// LC4 hazard unit
// load-use stall detection plus MX/WX operand and WM store-data bypass selection
module lc4_hazard_unit import lc4_pkg::*; (
    input  lc4_ctrl_t i_d_ctrl,
    input  lc4_ctrl_t i_x_ctrl,
    input  lc4_ctrl_t i_m_ctrl,
    input  lc4_ctrl_t i_w_ctrl,
    output logic      o_stall,
    output lc4_fwd_e  o_rs_fwd,
    output lc4_fwd_e  o_rt_fwd,
    output logic      o_store_fwd
);

    logic d_rs_hit, d_rt_hit;

    // nearest producer wins; a load in M has no value yet
    function automatic lc4_fwd_e fwd_src(input logic re, input lc4_rsel_t sel);
        lc4_fwd_e src;
        src = FWD_RF;
        if (re && i_m_ctrl.rd_we && !i_m_ctrl.is_load && i_m_ctrl.rd_sel == sel) begin
            src = FWD_M;
        end else if (re && i_w_ctrl.rd_we && i_w_ctrl.rd_sel == sel) begin
            src = FWD_W;
        end
        return src;
    endfunction

    assign d_rs_hit = i_d_ctrl.rs_re && i_d_ctrl.rs_sel == i_x_ctrl.rd_sel;

    // store data reaches M through the WM path, no need to wait for it
    assign d_rt_hit = i_d_ctrl.rt_re && !i_d_ctrl.is_store
                   && i_d_ctrl.rt_sel == i_x_ctrl.rd_sel;

    // a branch right behind a load needs the load's NZP
    assign o_stall = i_x_ctrl.is_load && (d_rs_hit || d_rt_hit || i_d_ctrl.is_branch);

    assign o_rs_fwd = fwd_src(i_x_ctrl.rs_re, i_x_ctrl.rs_sel);
    assign o_rt_fwd = fwd_src(i_x_ctrl.rt_re, i_x_ctrl.rt_sel);

    assign o_store_fwd = i_m_ctrl.is_store && i_w_ctrl.rd_we
                      && i_m_ctrl.rt_sel == i_w_ctrl.rd_sel;

endmodule

//--- lc4_pipeline.sv
// LC4 five-stage single-issue pipeline
// fetch, decode, execute, memory, writeback; bypassing, load-use stall,
// branch resolution in execute and a retirement trace out of writeback
`include "lc4_settings.svh"

module lc4_pipeline import lc4_pkg::*; (
    input  logic          gwe,
    input  logic          i_rst_n,
    output lc4_word_t     o_pc,
    input  lc4_insn_u     i_insn,
    output lc4_dmem_req_t o_dmem,
    input  lc4_word_t     i_dmem_rdata,
    output lc4_wb_t       o_wb
);

    function automatic logic [2:0] nzp_of(input lc4_word_t val);
        logic [2:0] nzp;
        if (val[`LC4_XLEN-1]) begin
            nzp = `LC4_NZP_N;
        end else if (val == '0) begin
            nzp = `LC4_NZP_Z;
        end else begin
            nzp = `LC4_NZP_P;
        end
        return nzp;
    endfunction

    lc4_word_t  pc_q, pc_next;
    lc4_stage_t d_q, d_cur, d_next, x_next;
    lc4_stage_t x_q, m_q, w_q;
    lc4_ctrl_t  dec_ctrl;
    logic       stall, br_taken, store_fwd;
    lc4_fwd_e   rs_fwd, rt_fwd;

    lc4_word_t  rf_rs, rf_rt;
    lc4_word_t  x_rs_q, x_rt_q, x_rs, x_rt, alu_out;
    lc4_word_t  m_result_q, m_store_q, m_store_data;
    lc4_word_t  w_result_q, w_addr_q, w_mem_q, w_wdata;
    logic [2:0] m_nzp_q, m_nzp, w_nzp_q, nzp_q, br_nzp;

    // fetch
    assign o_pc    = pc_q;
    assign pc_next = br_taken ? alu_out : pc_q + 1'b1;

    always_comb begin
        d_next       = '0;
        d_next.valid = !br_taken;       // squash the word fetched under a taken branch
        d_next.pc    = pc_q;
        d_next.insn  = i_insn;
    end

    // decode
    always_comb begin
        d_cur      = d_q;
        d_cur.ctrl = d_q.valid ? dec_ctrl : '0;
        x_next     = (br_taken || stall) ? '0 : d_cur;
    end

    lc4_decoder u_decoder (
        .i_insn (d_q.insn),
        .o_ctrl (dec_ctrl)
    );

    lc4_regfile u_regfile (
        .gwe       (gwe),
        .i_rst_n   (i_rst_n),
        .i_rs_sel  (d_cur.ctrl.rs_sel),
        .i_rt_sel  (d_cur.ctrl.rt_sel),
        .o_rs_data (rf_rs),
        .o_rt_data (rf_rt),
        .i_rd_sel  (w_q.ctrl.rd_sel),
        .i_rd_data (w_wdata),
        .i_rd_we   (w_q.ctrl.rd_we)
    );

    lc4_hazard_unit u_hazard (
        .i_d_ctrl    (d_cur.ctrl),
        .i_x_ctrl    (x_q.ctrl),
        .i_m_ctrl    (m_q.ctrl),
        .i_w_ctrl    (w_q.ctrl),
        .o_stall     (stall),
        .o_rs_fwd    (rs_fwd),
        .o_rt_fwd    (rt_fwd),
        .o_store_fwd (store_fwd)
    );

    // execute, MX and WX bypass
    always_comb begin
        case (rs_fwd)
            FWD_M:   x_rs = m_result_q;
            FWD_W:   x_rs = w_wdata;
            default: x_rs = x_rs_q;
        endcase
        case (rt_fwd)
            FWD_M:   x_rt = m_result_q;
            FWD_W:   x_rt = w_wdata;
            default: x_rt = x_rt_q;
        endcase
    end

    lc4_alu u_alu (
        .i_insn   (x_q.insn),
        .i_pc     (x_q.pc),
        .i_rs     (x_rs),
        .i_rt     (x_rt),
        .o_result (alu_out)
    );

    assign br_nzp   = m_q.ctrl.nzp_we ? m_nzp :
                      w_q.ctrl.nzp_we ? w_nzp_q : nzp_q;
    assign br_taken = x_q.ctrl.is_branch && |(x_q.insn.b.nzp & br_nzp);

    // memory, load NZP comes straight from the read data
    assign m_nzp        = m_q.ctrl.is_load ? nzp_of(i_dmem_rdata) : m_nzp_q;
    assign m_store_data = store_fwd ? w_wdata : m_store_q;     // WM bypass

    always_comb begin
        o_dmem       = '0;
        o_dmem.we    = m_q.ctrl.is_store;
        if (m_q.ctrl.is_load || m_q.ctrl.is_store) begin
            o_dmem.addr = m_result_q;
        end
        if (m_q.ctrl.is_store) begin
            o_dmem.wdata = m_store_data;
        end
    end

    // writeback
    assign w_wdata = w_q.ctrl.is_load ? w_mem_q : w_result_q;

    always_comb begin
        o_wb           = '0;
        o_wb.valid     = w_q.valid;
        o_wb.pc        = w_q.pc;
        o_wb.insn      = w_q.insn;
        o_wb.rd_we     = w_q.ctrl.rd_we;
        o_wb.rd_sel    = w_q.ctrl.rd_sel;
        o_wb.rd_data   = w_wdata;
        o_wb.nzp_we    = w_q.ctrl.nzp_we;
        o_wb.nzp       = w_nzp_q;
        o_wb.dmem_we   = w_q.ctrl.is_store;
        o_wb.dmem_addr = w_addr_q;
        o_wb.dmem_data = w_mem_q;
    end

    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc_q  <= `LC4_RESET_PC;
            d_q   <= '0;
            x_q   <= '0;
            m_q   <= '0;
            w_q   <= '0;
            nzp_q <= '0;
        end else begin
            if (!stall) begin                   // stall holds PC and the D slot
                pc_q <= pc_next;
                d_q  <= d_next;
            end
            x_q <= x_next;
            m_q <= x_q;
            w_q <= m_q;
            if (w_q.ctrl.nzp_we) begin
                nzp_q <= w_nzp_q;
            end
        end
    end

    always_ff @(posedge gwe) begin
        x_rs_q     <= rf_rs;
        x_rt_q     <= rf_rt;
        m_result_q <= alu_out;
        m_store_q  <= x_rt;
        m_nzp_q    <= nzp_of(alu_out);
        w_result_q <= m_result_q;
        w_addr_q   <= o_dmem.addr;
        w_mem_q    <= m_q.ctrl.is_load ? i_dmem_rdata : o_dmem.wdata;   // load or store data
        w_nzp_q    <= m_nzp;
    end

endmodule

//--- lc4_pkg.sv
// LC4 shared types
// instruction views, decoded control, pipeline slot, memory request and trace
`include "lc4_settings.svh"

package lc4_pkg;

    typedef logic [`LC4_XLEN-1:0]   lc4_word_t;
    typedef logic [`LC4_RSEL_W-1:0] lc4_rsel_t;

    // kept opcodes, everything else is a no-op
    typedef enum logic [3:0] {
        OP_BR    = 4'b0000,
        OP_ARITH = 4'b0001,
        OP_LOGIC = 4'b0101,
        OP_LDR   = 4'b0110,
        OP_STR   = 4'b0111,
        OP_CONST = 4'b1001
    } lc4_op_e;

    // register-form subops, arith and logic groups overlap in encoding
    localparam logic [2:0] SUB_ADD = 3'b000;
    localparam logic [2:0] SUB_SUB = 3'b010;
    localparam logic [2:0] SUB_AND = 3'b000;
    localparam logic [2:0] SUB_OR  = 3'b010;
    localparam logic [2:0] SUB_XOR = 3'b011;

    typedef struct packed {
        lc4_op_e   opcode;
        lc4_rsel_t rd;
        lc4_rsel_t rs;
        logic [2:0] subop;          // top bit doubles as the immediate flag
        lc4_rsel_t rt;
    } lc4_rform_t;

    typedef struct packed {
        lc4_op_e    opcode;
        lc4_rsel_t  rd;
        lc4_rsel_t  rs;
        logic       imm_flag;
        logic [4:0] imm5;
    } lc4_iform_t;

    typedef struct packed {
        lc4_op_e    opcode;
        lc4_rsel_t  rd;             // rt for a store
        lc4_rsel_t  rs;
        logic [5:0] imm6;
    } lc4_mform_t;

    typedef struct packed {
        lc4_op_e    opcode;
        logic [2:0] nzp;            // rd for CONST
        logic [8:0] imm9;
    } lc4_bform_t;

    typedef union packed {
        lc4_rform_t r;
        lc4_iform_t i;
        lc4_mform_t m;
        lc4_bform_t b;
    } lc4_insn_u;

    typedef struct packed {
        lc4_rsel_t rs_sel;
        lc4_rsel_t rt_sel;
        lc4_rsel_t rd_sel;
        logic      rs_re;
        logic      rt_re;
        logic      rd_we;
        logic      nzp_we;
        logic      is_load;
        logic      is_store;
        logic      is_branch;
    } lc4_ctrl_t;

    typedef struct packed {
        logic      valid;
        lc4_word_t pc;
        lc4_insn_u insn;
        lc4_ctrl_t ctrl;
    } lc4_stage_t;

    typedef struct packed {
        lc4_word_t addr;
        logic      we;
        lc4_word_t wdata;
    } lc4_dmem_req_t;

    typedef struct packed {
        logic       valid;
        lc4_word_t  pc;
        lc4_insn_u  insn;
        logic       rd_we;
        lc4_rsel_t  rd_sel;
        lc4_word_t  rd_data;
        logic       nzp_we;
        logic [2:0] nzp;
        logic       dmem_we;
        lc4_word_t  dmem_addr;
        lc4_word_t  dmem_data;
    } lc4_wb_t;

    typedef enum logic [1:0] {
        FWD_RF = 2'd0,
        FWD_M  = 2'd1,
        FWD_W  = 2'd2
    } lc4_fwd_e;

endpackage

//--- lc4_regfile.sv
// LC4 register file
// eight words, two read ports and one write port; a read of the register
// being written in the same cycle returns the new data
`include "lc4_settings.svh"

module lc4_regfile (
    input  logic                   gwe,
    input  logic                   i_rst_n,
    input  logic [`LC4_RSEL_W-1:0] i_rs_sel,
    input  logic [`LC4_RSEL_W-1:0] i_rt_sel,
    output logic [`LC4_XLEN-1:0]   o_rs_data,
    output logic [`LC4_XLEN-1:0]   o_rt_data,
    input  logic [`LC4_RSEL_W-1:0] i_rd_sel,
    input  logic [`LC4_XLEN-1:0]   i_rd_data,
    input  logic                   i_rd_we
);

    logic [`LC4_XLEN-1:0] regs [`LC4_NREGS];

    always_ff @(posedge gwe or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < `LC4_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_rd_we) begin
            regs[i_rd_sel] <= i_rd_data;
        end
    end

    assign o_rs_data = (i_rd_we && i_rd_sel == i_rs_sel) ? i_rd_data : regs[i_rs_sel];
    assign o_rt_data = (i_rd_we && i_rd_sel == i_rt_sel) ? i_rd_data : regs[i_rt_sel];

endmodule

//--- lc4_settings.svh
// LC4 core settings
// word and register sizes, reset fetch address, condition code encodings
`ifndef LC4_SETTINGS_SVH
`define LC4_SETTINGS_SVH

`define LC4_XLEN      16            // data and address width
`define LC4_NREGS     8
`define LC4_RSEL_W    3             // register select width
`define LC4_RESET_PC  16'h8200      // first fetch address

// one-hot condition codes
`define LC4_NZP_N     3'b100
`define LC4_NZP_Z     3'b010
`define LC4_NZP_P     3'b001

`endif

//--- lc4_stimulus.txt
# columns: pc insn kind, then rd data nzp for kind r, addr data for kind s
# kind n retires with nothing to check, kind x is jumped over and never retires
test arith
8200 9205 r 1 0005 1
8201 95fd r 2 fffd 4
8202 1642 r 3 0002 1
8203 1852 r 4 0008 1
8204 5a42 r 5 0005 1
8205 5c52 r 6 fffd 4
8206 5e5a r 7 fff8 4
8207 16fe r 3 0000 2
8208 592c r 4 0008 1
test bypass
8209 1241 r 1 000a 1
820a 1241 r 1 0014 1
820b 1521 r 2 0009 1
820c 1a42 r 5 001d 1
test memory
820d 9c20 r 6 0020 1
820e 1f63 r 7 0020 1
820f 7f81 s 0021 0020
test loaduse
8210 6381 r 1 0020 1
8211 1441 r 2 0040 1
8212 6782 r 3 dd22 4
8213 0801 n
8214 99ff x
8215 18e0 r 4 dd22 4
test branch
8216 9a00 r 5 0000 2
8217 0a02 n
8218 1b67 r 5 0007 1
8219 0201 n
821a 9c55 x
821b 0001 n
821c 9dfb r 6 fffb 4
821d 0fff n

//--- lc4_tb.sv
// LC4 pipeline testbench
// loads program and expected retirements from the stimulus file, runs the core
// against small memory models and compares every register write and store
`include "lc4_settings.svh"

module lc4_tb import lc4_pkg::*; ;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAXREC = 64;

    logic          gwe, i_rst_n;
    lc4_word_t     o_pc, i_dmem_rdata;
    lc4_insn_u     i_insn;
    lc4_dmem_req_t o_dmem;
    lc4_wb_t       o_wb;

    lc4_word_t  imem [256];
    lc4_word_t  dmem [256];
    int         wr_count;               // bumps on each store so reads see it
    logic       rec_store [MAXREC];
    lc4_word_t  rec_pc [MAXREC], rec_a [MAXREC], rec_b [MAXREC], rec_c [MAXREC];
    lc4_word_t  rec_insn [MAXREC];
    int         rec_test [MAXREC];
    logic [8*16-1:0] test_name [16];
    int         nrec, ntest, checks, errors;

    lc4_tb_clk u_clk (.o_gwe(gwe), .o_rst_n(i_rst_n));

    lc4_pipeline i_dut (
        .gwe          (gwe),
        .i_rst_n      (i_rst_n),
        .o_pc         (o_pc),
        .i_insn       (i_insn),
        .o_dmem       (o_dmem),
        .i_dmem_rdata (i_dmem_rdata),
        .o_wb         (o_wb)
    );

    function automatic int mem_index(input lc4_word_t addr);
        lc4_word_t off;
        off = addr - `LC4_RESET_PC;
        return int'(off[7:0]);
    endfunction

    // memories answer in the same cycle, updated right after the clock edge
    always @(posedge gwe or o_pc or o_dmem.addr or wr_count) begin
        i_insn       <= imem[mem_index(o_pc)];
        i_dmem_rdata <= dmem[mem_index(o_dmem.addr)];
    end

    always @(posedge gwe) begin
        if (i_rst_n && o_dmem.we) begin
            dmem[mem_index(o_dmem.addr)] <= o_dmem.wdata;
            wr_count <= wr_count + 1;
        end
    end

    task automatic load_stimulus();
        int fd, n;
        logic [8*80-1:0] line;
        logic [8*16-1:0] first, kind;
        lc4_word_t pc, word, a, b, c;
        fd = $fopen("lc4_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = '0;
                n = $fgets(line, fd);
                first = '0;
                n = $sscanf(line, "%s", first);
                if (n < 1 || first == "#") begin
                    continue;
                end
                if (first == "test") begin
                    n = $sscanf(line, "%s %s", first, test_name[ntest]);
                    ntest++;
                    continue;
                end
                n = $sscanf(line, "%h %h %s %h %h %h", pc, word, kind, a, b, c);
                imem[mem_index(pc)] = word;
                if (kind == "r" || kind == "s") begin
                    rec_store[nrec] = (kind == "s");
                    rec_pc[nrec]    = pc;
                    rec_insn[nrec]  = word;
                    rec_a[nrec]     = a;
                    rec_b[nrec]     = b;
                    rec_c[nrec]     = c;
                    rec_test[nrec]  = ntest - 1;
                    nrec++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic finish_run();
        $display("tests %0d, checks %0d, errors %0d", ntest, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    task automatic compare(input int t, input string what, input lc4_word_t exp,
                           input lc4_word_t act, inout int fails);
        checks++;
        if (exp !== act) begin
            $display("FAIL %0s %0s: expected %h actual %h", test_name[t], what, exp, act);
            errors++;
            fails++;
        end
    endtask

    initial begin
        int cyc, fails;
        i_insn       = '0;
        i_dmem_rdata = '0;
        wr_count     = 0;
        nrec         = 0;
        ntest        = 0;
        checks       = 0;
        errors       = 0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;                           // empty-mask branch, a no-op
            dmem[i] = {~i[7:0], i[7:0]};
        end
        load_stimulus();
        fails = 0;

        // first fetch address once reset lets go
        cyc = 0;
        do begin
            @(negedge gwe);
            cyc++;
        end while (!i_rst_n && cyc < 200);
        checks++;
        if (cyc >= 200) begin
            $display("timeout: reset was never released within 200 cycles");
            errors++;
        end else if (o_pc !== `LC4_RESET_PC) begin
            $display("FAIL reset pc: expected %h actual %h", `LC4_RESET_PC, o_pc);
            errors++;
        end

        for (int r = 0; r < nrec; r++) begin
            cyc = 0;
            do begin                                // next write or store retirement
                @(negedge gwe);
                cyc++;
            end while (!(i_rst_n && o_wb.valid && (o_wb.rd_we || o_wb.dmem_we))
                       && cyc < 200);
            if (cyc >= 200) begin
                $display("timeout: no retirement within 200 cycles in test %0s",
                         test_name[rec_test[r]]);
                errors++;
                break;
            end
            compare(rec_test[r], "pc", rec_pc[r], o_wb.pc, fails);
            compare(rec_test[r], "insn", rec_insn[r], o_wb.insn, fails);
            compare(rec_test[r], "store", 16'(rec_store[r]), 16'(o_wb.dmem_we), fails);
            compare(rec_test[r], "rd_we", 16'(!rec_store[r]), 16'(o_wb.rd_we), fails);
            compare(rec_test[r], "nzp_we", 16'(!rec_store[r]), 16'(o_wb.nzp_we), fails);
            if (rec_store[r]) begin
                compare(rec_test[r], "addr", rec_a[r], o_wb.dmem_addr, fails);
                compare(rec_test[r], "sdata", rec_b[r], o_wb.dmem_data, fails);
            end else begin
                compare(rec_test[r], "rd", rec_a[r], 16'(o_wb.rd_sel), fails);
                compare(rec_test[r], "data", rec_b[r], o_wb.rd_data, fails);
                compare(rec_test[r], "nzp", rec_c[r], 16'(o_wb.nzp), fails);
            end
            if (r == nrec - 1 || rec_test[r + 1] != rec_test[r]) begin
                $display("test %0s finished, %0d failures", test_name[rec_test[r]], fails);
                fails = 0;
            end
        end
        finish_run();
    end

endmodule

//--- lc4_tb_clk.sv
// LC4 testbench clock and reset
// 4 ns gwe clock, reset held low for the first four cycles
module lc4_tb_clk (
    output logic o_gwe,
    output logic o_rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        o_gwe   = 1'b0;
        o_rst_n = 1'b0;
        repeat (4) @(posedge o_gwe);
        o_rst_n <= 1'b1;
    end

    always #2 o_gwe = ~o_gwe;

endmodule

//--- list.f
+incdir+.
lc4_pkg.sv
lc4_decoder.sv
lc4_regfile.sv
lc4_alu.sv
lc4_hazard_unit.sv
lc4_pipeline.sv
lc4_tb_clk.sv
lc4_chk.sv
lc4_tb.sv

//--- run.sh
#!/bin/bash
# build and run the LC4 pipeline testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f list.f --top-module lc4_tb -o lc4_sim &&
./obj_dir/lc4_sim > sim.log 2>&1
cat sim.log
grep -q "Done: errors found" sim.log && { echo "simulation FAILED"; exit 1; } ||
grep -q "Done: no errors" sim.log || { echo "simulation did not complete"; exit 1; }
